// ==== source/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// instruction word and address width
`define FETCH_XLEN 32

// pc and word read address out of reset
`define FETCH_RESET_PC 32'h0000_0200

// host register word indices
`define REG_CTRL 2'd0
`define REG_BOOT_PC 2'd1
`define REG_COUNT 2'd2

`endif

// ==== source/fetch_pkg.sv ====
`include "fetch_params.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0] word_t;    // instruction word or byte address
    typedef logic [15:0] half_t;               // one 16-bit parcel
    typedef logic [1:0] reg_idx_t;             // host register word index

    typedef enum logic {
        LEN_16,                                // compressed parcel
        LEN_32                                 // first parcel of a full instruction
    } instr_len_e;

    // low two bits of 11 open a full 32-bit instruction
    function automatic instr_len_e parcel_len(input half_t parcel);
        if (parcel[1:0] == 2'b11) begin
            return LEN_32;
        end
        return LEN_16;
    endfunction

    // word reads are always aligned to four bytes
    function automatic word_t align_word(input word_t addr);
        word_t aligned;
        aligned = addr;
        aligned[1:0] = 2'b00;
        return aligned;
    endfunction

endpackage

// ==== source/word_stream_if.sv ====
`timescale 1ns/100ps

interface word_stream_if;
    import fetch_pkg::*;

    // aligner side
    word_t read_addr;       // next aligned word to read
    logic  slot_free;       // output slot empty or emptying now

    // fetcher side
    word_t word;            // read data from the bus
    logic  arrived;         // one-cycle pulse per accepted word
    logic  restart;         // one-cycle restart pulse
    word_t restart_pc;      // may be halfword aligned

    modport fetcher (
        input  read_addr,
        input  slot_free,
        output word,
        output arrived,
        output restart,
        output restart_pc
    );

    modport aligner (
        output read_addr,
        output slot_free,
        input  word,
        input  arrived,
        input  restart,
        input  restart_pc
    );

endinterface

// ==== source/fetch_control_regs.sv ====
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_control_regs (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                host_cyc,
    input  logic                host_stb,
    input  logic                host_we,
    input  fetch_pkg::reg_idx_t host_adr,
    input  fetch_pkg::word_t    host_dat_w,
    input  logic                redirect_taken,
    input  logic                instr_taken,
    output fetch_pkg::word_t    host_dat_r,
    output logic                host_ack,
    output logic                run,
    output logic                redirect_req,
    output fetch_pkg::word_t    redirect_pc
);
    import fetch_pkg::*;

    logic  access;          // host cycle served on this edge
    logic  wr_en;
    word_t count;           // instructions delivered since reset

    // the ack term keeps a held stb from being served twice
    assign access = host_cyc & host_stb & ~host_ack;
    assign wr_en = access & host_we;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            host_ack <= 1'b0;
            run <= 1'b0;
            redirect_req <= 1'b0;
            redirect_pc <= `FETCH_RESET_PC;
            count <= '0;
        end else begin
            host_ack <= access;
            if (wr_en && host_adr == `REG_CTRL) begin
                run <= host_dat_w[0];
            end
            // a fresh write wins over the fetcher taking an older request
            if (wr_en && host_adr == `REG_BOOT_PC) begin
                redirect_pc <= host_dat_w;
                redirect_req <= 1'b1;
            end else if (redirect_taken) begin
                redirect_req <= 1'b0;
            end
            if (instr_taken) begin
                count <= count + word_t'(1);
            end
        end
    end

    // read data is captured with the ack
    always_ff @(posedge clk) begin
        if (access && !host_we) begin
            case (host_adr)
                `REG_CTRL:    host_dat_r <= word_t'({redirect_req, run});   // bit 1 pending
                `REG_BOOT_PC: host_dat_r <= redirect_pc;
                `REG_COUNT:   host_dat_r <= count;
                default:      host_dat_r <= '0;
            endcase
        end
    end

    host_ack_single: assert property (@(posedge clk) disable iff (!n_rst)
        host_ack |=> !host_ack);

endmodule

// ==== source/word_fetcher.sv ====
`timescale 1ns/100ps

module word_fetcher (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             run,
    input  logic             redirect_req,
    input  fetch_pkg::word_t redirect_pc,
    input  fetch_pkg::word_t mem_dat_r,
    input  logic             mem_ack,
    output logic             redirect_taken,
    output logic             mem_cyc,
    output logic             mem_stb,
    output fetch_pkg::word_t mem_adr,
    word_stream_if.fetcher   stream
);

    typedef enum logic {
        IDLE,
        BUSY
    } bus_state_e;

    bus_state_e state;
    logic       start;      // open a read cycle on this edge

    // a redirect is only taken with no cycle open
    assign redirect_taken = (state == IDLE) && redirect_req;

    // no read while a redirect is pending or the aligner is reloading
    assign start = (state == IDLE) && run && stream.slot_free
                   && !redirect_req && !stream.restart;

    assign mem_cyc = (state == BUSY);
    assign mem_stb = (state == BUSY);   // classic cycle, stb follows cyc

    assign stream.word = mem_dat_r;

    // a redirect that showed up during the cycle leaves its data stale
    assign stream.arrived = (state == BUSY) && mem_ack && !redirect_req;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= IDLE;
            stream.restart <= 1'b0;
        end else begin
            stream.restart <= redirect_taken;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (mem_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_adr <= stream.read_addr;    // held until ack
        end
        if (redirect_taken) begin
            stream.restart_pc <= redirect_pc;
        end
    end

    mem_adr_stable: assert property (@(posedge clk) disable iff (!n_rst)
        mem_stb && !mem_ack |=> $stable(mem_adr));

endmodule

// ==== source/inst_aligner.sv ====
`timescale 1ns/100ps
`include "fetch_params.svh"

module inst_aligner (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             instr_ready,
    output fetch_pkg::word_t instr,
    output fetch_pkg::word_t instr_pc,
    output logic             instr_valid,
    output logic             instr_taken,
    word_stream_if.aligner   stream
);
    import fetch_pkg::*;

    localparam word_t STEP_HALF = 2;
    localparam word_t STEP_WORD = 4;

    half_t      buffer, next_buffer;    // upper parcel kept from the last word
    word_t      pc, next_pc;            // pc of the next instruction to deliver
    word_t      read_addr, next_read_addr;
    logic       combine_q, next_combine;    // buffer holds the low half of a straddler
    logic       loadbuf_q, next_loadbuf;    // buffer holds a compressed instruction
    logic       restart_q;              // first word after a restart
    word_t      final_instr;
    logic       finished;               // this word completes an instruction
    half_t      lower, upper;
    instr_len_e lower_len, upper_len;

    assign lower = stream.word[15:0];
    assign upper = stream.word[31:16];
    assign lower_len = parcel_len(lower);
    assign upper_len = parcel_len(upper);

    assign instr_taken = instr_valid & instr_ready;
    assign stream.slot_free = ~instr_valid | instr_ready;
    assign stream.read_addr = read_addr;

    always_comb begin
        next_buffer = buffer;
        next_pc = pc;
        next_read_addr = read_addr;
        next_combine = 1'b0;
        next_loadbuf = 1'b0;
        final_instr = stream.word;
        finished = 1'b0;
        if (restart_q && pc[1]) begin           // restarted into an upper half
            next_read_addr = read_addr + STEP_WORD;
            if (upper_len == LEN_16) begin
                final_instr = {16'h0000, upper};
                next_pc = pc + STEP_HALF;
                finished = 1'b1;
            end else begin
                next_combine = 1'b1;            // wait for the next word
                next_buffer = upper;
            end
        end else if (combine_q) begin           // join across the word boundary
            final_instr = {lower, buffer};
            next_buffer = upper;
            next_pc = pc + STEP_WORD;
            finished = 1'b1;
            if (upper_len == LEN_16) begin
                next_loadbuf = 1'b1;            // same word again to drain the buffer
            end else begin
                next_combine = 1'b1;
                next_read_addr = read_addr + STEP_WORD;
            end
        end else if (loadbuf_q) begin           // word data is a repeat
            final_instr = {16'h0000, buffer};
            next_pc = pc + STEP_HALF;
            next_read_addr = read_addr + STEP_WORD;
            finished = 1'b1;
        end else if (lower_len == LEN_16) begin
            final_instr = {16'h0000, lower};
            next_buffer = upper;
            next_pc = pc + STEP_HALF;
            finished = 1'b1;
            if (upper_len == LEN_16) begin
                next_loadbuf = 1'b1;
            end else begin
                next_combine = 1'b1;
                next_read_addr = read_addr + STEP_WORD;
            end
        end else begin                          // plain aligned 32-bit word
            next_pc = pc + STEP_WORD;
            next_read_addr = read_addr + STEP_WORD;
            finished = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pc <= `FETCH_RESET_PC;
            read_addr <= `FETCH_RESET_PC;
            combine_q <= 1'b0;
            loadbuf_q <= 1'b0;
            restart_q <= 1'b0;
            instr_valid <= 1'b0;
        end else if (stream.restart) begin
            pc <= stream.restart_pc;            // may be misaligned
            read_addr <= align_word(stream.restart_pc);
            combine_q <= 1'b0;
            loadbuf_q <= 1'b0;
            restart_q <= 1'b1;
            instr_valid <= 1'b0;                // old stream is flushed
        end else begin
            if (stream.arrived) begin
                pc <= next_pc;
                read_addr <= next_read_addr;
                combine_q <= next_combine;
                loadbuf_q <= next_loadbuf;
                restart_q <= 1'b0;
            end
            // a read only starts with the slot free, so a load never meets a full slot
            if (stream.arrived && finished) begin
                instr_valid <= 1'b1;
            end else if (instr_taken) begin
                instr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stream.arrived) begin
            buffer <= next_buffer;
        end
        if (stream.arrived && finished) begin
            instr <= final_instr;
            instr_pc <= pc;
        end
    end

    compressed_zero_ext: assert property (@(posedge clk) disable iff (!n_rst)
        instr_taken && parcel_len(instr[15:0]) == LEN_16 |-> instr[31:16] == 16'h0000);

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top (
    input  logic                clk,
    input  logic                n_rst,
    // host register port
    input  logic                host_cyc,
    input  logic                host_stb,
    input  logic                host_we,
    input  fetch_pkg::reg_idx_t host_adr,
    input  fetch_pkg::word_t    host_dat_w,
    output fetch_pkg::word_t    host_dat_r,
    output logic                host_ack,
    // instruction memory port
    output logic                mem_cyc,
    output logic                mem_stb,
    output fetch_pkg::word_t    mem_adr,
    input  fetch_pkg::word_t    mem_dat_r,
    input  logic                mem_ack,
    // instruction output slot
    output fetch_pkg::word_t    instr,
    output fetch_pkg::word_t    instr_pc,
    output logic                instr_valid,
    input  logic                instr_ready
);
    import fetch_pkg::*;

    logic  run;
    logic  redirect_req;
    logic  redirect_taken;
    word_t redirect_pc;
    logic  instr_taken;     // one per transfer, feeds the counter

    word_stream_if stream ();

    fetch_control_regs regs_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .host_cyc       (host_cyc),
        .host_stb       (host_stb),
        .host_we        (host_we),
        .host_adr       (host_adr),
        .host_dat_w     (host_dat_w),
        .redirect_taken (redirect_taken),
        .instr_taken    (instr_taken),
        .host_dat_r     (host_dat_r),
        .host_ack       (host_ack),
        .run            (run),
        .redirect_req   (redirect_req),
        .redirect_pc    (redirect_pc)
    );

    word_fetcher fetcher_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .run            (run),
        .redirect_req   (redirect_req),
        .redirect_pc    (redirect_pc),
        .mem_dat_r      (mem_dat_r),
        .mem_ack        (mem_ack),
        .redirect_taken (redirect_taken),
        .mem_cyc        (mem_cyc),
        .mem_stb        (mem_stb),
        .mem_adr        (mem_adr),
        .stream         (stream.fetcher)
    );

    inst_aligner aligner_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .instr_ready    (instr_ready),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .instr_valid    (instr_valid),
        .instr_taken    (instr_taken),
        .stream         (stream.aligner)
    );

endmodule

// ==== bench/imem_model.sv ====
`timescale 1ns/100ps

module imem_model (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             cyc,
    input  logic             stb,
    input  fetch_pkg::word_t adr,
    output fetch_pkg::word_t dat_r,
    output logic             ack
);
    import fetch_pkg::*;

    word_t      mem [0:255];    // 1 KiB image, aliased over the whole address space
    logic       busy;           // wait states drawn for the open access
    logic [1:0] wait_left;

    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ack <= 1'b0;
            busy <= 1'b0;
            wait_left <= 2'd0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (!busy) begin
                    busy <= 1'b1;
                    wait_left <= 2'($urandom_range(3, 0));
                end else if (wait_left == 2'd0) begin
                    ack <= 1'b1;            // single-cycle ack per classic cycle
                    busy <= 1'b0;
                    dat_r <= mem[adr[9:2]];
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

endmodule

// ==== bench/fetch_tb.sv ====
`timescale 1ns/100ps
`include "fetch_params.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int WAIT_LIMIT = 2000;  // cycles per wait

    logic     clk = 1'b0;
    logic     n_rst = 1'b0;
    logic     host_cyc = 1'b0;
    logic     host_stb = 1'b0;
    logic     host_we = 1'b0;
    reg_idx_t host_adr = '0;
    word_t    host_dat_w = '0;
    word_t    host_dat_r;
    logic     host_ack;
    logic     mem_cyc, mem_stb, mem_ack;
    word_t    mem_adr, mem_dat_r;
    word_t    instr, instr_pc;
    logic     instr_valid;
    logic     instr_ready = 1'b0;

    half_t    prog [0:511];         // program image, one entry per halfword
    word_t    exp_pc;               // pc of the next instruction owed by the DUT
    word_t    exp_instr;
    word_t    load_pc = '0;
    logic     load_exp = 1'b0;
    logic     hold_ready = 1'b1;    // ready stays low until the first test
    word_t    prev_instr, prev_pc;
    int       xfer_count;
    int       xfer_errors = 0;
    int       hold_errors = 0;
    int       errors = 0;
    int       seen_errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    string    test_name = "reset";

    fetch_top fetch_top_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .host_cyc    (host_cyc),
        .host_stb    (host_stb),
        .host_we     (host_we),
        .host_adr    (host_adr),
        .host_dat_w  (host_dat_w),
        .host_dat_r  (host_dat_r),
        .host_ack    (host_ack),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_adr     (mem_adr),
        .mem_dat_r   (mem_dat_r),
        .mem_ack     (mem_ack),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready)
    );

    imem_model imem_inst (
        .clk   (clk),
        .n_rst (n_rst),
        .cyc   (mem_cyc),
        .stb   (mem_stb),
        .adr   (mem_adr),
        .dat_r (mem_dat_r),
        .ack   (mem_ack)
    );

    initial begin
        forever begin
            #50 clk = ~clk;
        end
    end

    // a parcel ending in binary 11 opens a 32-bit instruction
    function automatic word_t ref_instr(input word_t p);
        half_t      first;
        instr_len_e len;
        first = prog[p[9:1]];
        len = (first[1:0] == 2'b11) ? LEN_32 : LEN_16;
        if (len == LEN_32) begin
            return {prog[p[9:1] + 9'd1], first};
        end
        return {16'h0000, first};
    endfunction

    function automatic word_t ref_next(input word_t p);
        half_t first;
        first = prog[p[9:1]];
        if (first[1:0] == 2'b11) begin
            return p + 32'd4;
        end
        return p + 32'd2;
    endfunction

    assign exp_instr = ref_instr(exp_pc);

    always @(posedge clk) begin
        if (hold_ready) begin
            instr_ready <= 1'b0;
        end else begin
            instr_ready <= ($urandom_range(3, 0) != 0);    // about one gap in four
        end
    end

    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            exp_pc <= `FETCH_RESET_PC;
            xfer_count <= 0;
        end else begin
            if (load_exp) begin
                exp_pc <= load_pc;
            end else if (instr_valid && instr_ready) begin
                exp_pc <= ref_next(exp_pc);
            end
            if (instr_valid && instr_ready) begin
                xfer_count <= xfer_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        prev_instr <= instr;
        prev_pc <= instr_pc;
    end

    transfer_matches: assert property (@(posedge clk) disable iff (!n_rst)
        instr_valid && instr_ready |-> instr == exp_instr && instr_pc == exp_pc)
    else begin
        $display("[FAIL] %s: expected %h at pc %h, got %h at pc %h", test_name,
                 $sampled(exp_instr), $sampled(exp_pc), $sampled(instr), $sampled(instr_pc));
        xfer_errors++;
    end

    // a redirect may empty the slot, but a held entry never changes
    slot_held: assert property (@(posedge clk) disable iff (!n_rst)
        instr_valid && !instr_ready |=> !instr_valid || ($stable(instr) && $stable(instr_pc)))
    else begin
        $display("[FAIL] %s: held slot expected %h at pc %h, got %h at pc %h", test_name,
                 $sampled(prev_instr), $sampled(prev_pc), $sampled(instr), $sampled(instr_pc));
        hold_errors++;
    end

    // classic master raises cyc and stb together
    bus_strobe_pairs: assert property (@(posedge clk) disable iff (!n_rst)
        mem_cyc == mem_stb)
    else begin
        $display("memory bus cyc and stb disagree in test %s", test_name);
        errors++;
    end

    bus_cycle_held: assert property (@(posedge clk) disable iff (!n_rst)
        mem_cyc && !mem_ack |=> mem_cyc && $stable(mem_adr))
    else begin
        $display("memory bus cycle ended or moved its address before ack in test %s",
                 test_name);
        errors++;
    end

    task automatic build_program();
        for (int a = 0; a < 1024; a += 2) begin
            prog[9'(a / 2)] = 16'((a * 32'h9e37_79b9) >> 11);   // hash mixes both lengths
        end
        for (int a = 'h200; a < 'h240; a += 4) begin           // aligned full words
            prog[9'(a / 2)] = {a[11:0], 4'h3};
            prog[9'(a / 2 + 1)] = ~a[15:0];
        end
        for (int a = 'h240; a < 'h262; a += 2) begin           // compressed pairs
            prog[9'(a / 2)] = {4'hc, a[11:0]};
        end
        for (int a = 'h262; a < 'h27e; a += 4) begin           // each one straddles a word
            prog[9'(a / 2)] = {a[11:0], 4'h7};
            prog[9'(a / 2 + 1)] = {4'hd, a[11:0]};
        end
        prog[9'('h27e / 2)] = 16'hc27e;
        for (int k = 0; k < 256; k++) begin
            imem_inst.mem[8'(k)] = {prog[9'(2 * k + 1)], prog[9'(2 * k)]};
        end
    endtask

    task automatic host_access(input logic we, input reg_idx_t adr, input word_t data,
                               output word_t rdata);
        int waited;
        @(posedge clk);
        host_cyc <= 1'b1;
        host_stb <= 1'b1;
        host_we <= we;
        host_adr <= adr;
        host_dat_w <= data;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!host_ack && waited < 20);
        rdata = host_dat_r;
        host_cyc <= 1'b0;
        host_stb <= 1'b0;
        host_we <= 1'b0;
        if (!host_ack) begin
            $display("host access to register %0d was never acknowledged", adr);
            errors++;
        end
    endtask

    task automatic wait_for_pc(input word_t target);
        int waited;
        waited = 0;
        while (exp_pc != target && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_pc != target) begin
            $display("instruction stream never reached pc %h", target);
            errors++;
        end
    endtask

    task automatic wait_for_transfers(input int count);
        int waited;
        int target;
        waited = 0;
        target = xfer_count + count;
        while (xfer_count < target && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (xfer_count < target) begin
            $display("only %0d of %0d transfers arrived", count - (target - xfer_count), count);
            errors++;
        end
    endtask

    // slot is frozen until the flush is done, so nothing old can slip through
    task automatic redirect_to(input word_t pc);
        word_t rdata;
        int    polls;
        hold_ready <= 1'b1;
        @(posedge clk);
        host_access(1'b1, `REG_BOOT_PC, pc, rdata);
        load_pc <= pc;
        load_exp <= 1'b1;
        @(posedge clk);
        load_exp <= 1'b0;
        polls = 0;
        do begin
            host_access(1'b0, `REG_CTRL, '0, rdata);   // bit 1 is the pending flag
            polls++;
        end while (rdata[1] && polls < 20);
        if (rdata[1]) begin
            $display("redirect to %h was never taken by the fetcher", pc);
            errors++;
        end
        hold_ready <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
    endtask

    task automatic finish_test();
        int total;
        total = errors + xfer_errors + hold_errors;
        tests_run++;
        if (total == seen_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, total - seen_errors);
            tests_failed++;
        end
        seen_errors = total;
    endtask

    initial begin
        word_t rdata;
        int    waited;
        void'($urandom(80757));
        build_program();
        repeat (4) @(posedge clk);
        n_rst <= 1'b1;

        start_test("full_words");
        hold_ready <= 1'b0;
        host_access(1'b1, `REG_CTRL, 32'd1, rdata);
        wait_for_pc(32'h240);
        finish_test();

        start_test("compressed_pairs");
        wait_for_pc(32'h260);
        finish_test();

        start_test("straddling");
        wait_for_pc(32'h280);
        finish_test();

        start_test("misaligned_redirect");
        redirect_to(32'h242);                   // compressed upper half
        wait_for_pc(32'h260);
        redirect_to(32'h262);                   // full instruction in the upper half
        wait_for_pc(32'h280);
        finish_test();

        start_test("back_pressure");
        hold_ready <= 1'b1;
        waited = 0;
        while (!instr_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!instr_valid) begin
            $display("output slot never filled while ready was low");
            errors++;
        end
        repeat (10) @(posedge clk);
        hold_ready <= 1'b0;
        wait_for_transfers(24);
        finish_test();

        start_test("delivered_count");
        hold_ready <= 1'b1;
        host_access(1'b0, `REG_COUNT, '0, rdata);
        count_matches: assert (rdata == word_t'(xfer_count))
        else begin
            $display("[FAIL] %s: expected %0d, got %0d", test_name, xfer_count, rdata);
            errors++;
        end
        finish_test();

        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
                 errors + xfer_errors + hold_errors);
        if (errors + xfer_errors + hold_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== fetch_unit.f ====
+incdir+source
source/fetch_pkg.sv
source/word_stream_if.sv
source/fetch_control_regs.sv
source/word_fetcher.sv
source/inst_aligner.sv
source/fetch_top.sv
bench/imem_model.sv
bench/fetch_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := fetch_tb
FILELIST := fetch_unit.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Verification failed

SOURCES  := $(wildcard source/*.sv source/*.svh bench/*.sv)
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# a crashed or aborted run also counts as a failure
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
